// File: Makefile
# Verilator build for the miner register block testbench

SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cl_miner_regs
FILELIST = all.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+tb
design/cl_regs_pkg.sv
design/axil_ctrl.sv
design/led_status.sv
design/miner_cmd_regs.sv
design/tick_counter.sv
design/cl_miner_regs.sv
tb/tb_cl_miner_regs.sv

// File: design/axil_ctrl.sv
/*
 * AXI4-Lite slave control
 * Single-beat write and read FSMs, always OKAY
 * Write beats go out as a one-cycle register write to the datapath,
 * reads are muxed by address and registered into rdata
 */

`timescale 1ns/1ps
`default_nettype none

module axil_ctrl import cl_regs_pkg::*;
(
  input  wire logic                  clk_main_a0,
  input  wire logic                  rst_main_n_sync,
  // AXI4-Lite slave
  input  wire logic                  awvalid,
  input  wire logic [addr_w-1:0]     awaddr,
  output logic                       awready,
  input  wire logic                  wvalid,
  input  wire logic [data_w-1:0]     wdata,
  // Byte strobes not honoured, all registers are full words
  input  wire logic [data_w/8-1:0]   wstrb,
  output logic                       wready,
  output logic                       bvalid,
  output logic [1:0]                 bresp,
  input  wire logic                  bready,
  input  wire logic                  arvalid,
  input  wire logic [addr_w-1:0]     araddr,
  output logic                       arready,
  output logic                       rvalid,
  output logic [data_w-1:0]          rdata,
  output logic [1:0]                 rresp,
  input  wire logic                  rready,
  // Register write toward datapath
  output logic                       reg_wr_en,
  output logic [addr_w-1:0]          reg_wr_addr,
  output logic [data_w-1:0]          reg_wr_data,
  // Read sources
  input  wire logic [data_w-1:0]     hello_swapped,
  input  wire logic [led_w-1:0]      vled_value,
  input  wire logic [data_w-1:0]     nonce_size_value,
  input  wire logic [hash_sel_w-1:0] hash_select_value,
  input  wire logic [1:0]            miner_status,
  input  wire logic [data_w-1:0]     nonce,
  input  wire logic [data_w-1:0]     heavyhash,
  input  wire logic [cnt_w-1:0]      cnt_value,
  input  wire logic                  cnt_ge_watermark,
  // Advance pulse to the miner
  output logic                       hash_re
);

  wr_state_t         wr_state;
  rd_state_t         rd_state;
  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  logic [data_w-1:0] rd_mux;

  // ------------------------------
  // Write path
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_state <= wr_idle;
      wr_addr  <= '0;
    end
    else
    begin
      case (wr_state)
        wr_idle:
        begin
          // Capture address on AW handshake
          if (awvalid)
          begin
            wr_addr  <= awaddr;
            wr_state <= wr_data;
          end
        end
        wr_data:
          if (wvalid)
            wr_state <= wr_resp;
        wr_resp:
          if (bready)
            wr_state <= wr_idle;
        default:
          wr_state <= wr_idle;
      endcase
    end
  end

  assign awready = (wr_state == wr_idle);
  assign wready  = (wr_state == wr_data) && wvalid;
  assign bvalid  = (wr_state == wr_resp);
  assign bresp   = resp_okay;

  // One-cycle write strobe on the data beat
  assign reg_wr_en   = wready;
  assign reg_wr_addr = wr_addr;
  assign reg_wr_data = wdata;

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb
  begin
    case (rd_addr)
      hello_addr:      rd_mux = hello_swapped;
      vled_addr:       rd_mux = {{(data_w-led_w){1'b0}}, vled_value};
      nonce_size_addr: rd_mux = nonce_size_value;
      hash_sel_addr:   rd_mux = {{(data_w-hash_sel_w){1'b0}}, hash_select_value};
      status_addr:     rd_mux = {{(data_w-2){1'b0}}, miner_status};
      nonce_addr:      rd_mux = nonce;
      heavyhash_addr:  rd_mux = heavyhash;
      // Flag sits just above the count
      cnt_addr:        rd_mux = {{(data_w-cnt_w-1){1'b0}}, cnt_ge_watermark, cnt_value};
      default:         rd_mux = unmapped_value;
    endcase
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_state <= rd_idle;
      rd_addr  <= '0;
      rdata    <= '0;
    end
    else
    begin
      case (rd_state)
        rd_idle:
        begin
          if (arvalid)
          begin
            rd_addr  <= araddr;
            rd_state <= rd_fetch;
          end
        end
        rd_fetch:
        begin
          rdata    <= rd_mux;
          rd_state <= rd_resp;
        end
        rd_resp:
          if (rready)
            rd_state <= rd_idle;
        default:
          rd_state <= rd_idle;
      endcase
    end
  end

  assign arready = (rd_state == rd_idle);
  assign rvalid  = (rd_state == rd_resp);
  assign rresp   = resp_okay;

  // Miner advances its result slot as the heavyhash word is sampled
  assign hash_re = (rd_state == rd_fetch) && (rd_addr == heavyhash_addr);

endmodule

`default_nettype wire

// File: design/cl_miner_regs.sv
/*
 * Miner accelerator register block
 * AXI4-Lite slave control plus hello/LED, miner command
 * and tick counter register groups
 */

`timescale 1ns/1ps
`default_nettype none

module cl_miner_regs import cl_regs_pkg::*;
(
  input  wire logic                  clk_main_a0,
  input  wire logic                  rst_main_n_sync,
  // AXI4-Lite slave
  input  wire logic                  awvalid,
  input  wire logic [addr_w-1:0]     awaddr,
  output logic                       awready,
  input  wire logic                  wvalid,
  input  wire logic [data_w-1:0]     wdata,
  input  wire logic [data_w/8-1:0]   wstrb,
  output logic                       wready,
  output logic                       bvalid,
  output logic [1:0]                 bresp,
  input  wire logic                  bready,
  input  wire logic                  arvalid,
  input  wire logic [addr_w-1:0]     araddr,
  output logic                       arready,
  output logic                       rvalid,
  output logic [data_w-1:0]          rdata,
  output logic [1:0]                 rresp,
  input  wire logic                  rready,
  // Miner core
  output logic [data_w-1:0]          block_header,
  output logic                       block_header_we,
  output logic [data_w-1:0]          matrix_in,
  output logic                       matrix_we,
  output logic [data_w-1:0]          target,
  output logic                       target_we,
  output logic [data_w-1:0]          nonce_size,
  output logic                       start,
  output logic                       stop,
  output logic [hash_sel_w-1:0]      hash_select,
  output logic                       hash_re,
  input  wire logic [1:0]            miner_status,
  input  wire logic [data_w-1:0]     nonce,
  input  wire logic [data_w-1:0]     heavyhash,
  // Virtual DIP and LED
  input  wire logic [led_w-1:0]      vdip,
  output logic [led_w-1:0]           vled
);

  // Internal register write bus
  logic              reg_wr_en;
  logic [addr_w-1:0] reg_wr_addr;
  logic [data_w-1:0] reg_wr_data;
  // Readback
  logic [data_w-1:0] hello_swapped;
  logic [led_w-1:0]  vled_value;
  logic [cnt_w-1:0]  cnt_value;
  logic              cnt_ge_watermark;

  // ------------------------------
  // Bus control
  // ------------------------------
  axil_ctrl u_axil_ctrl (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .awvalid           (awvalid),
    .awaddr            (awaddr),
    .awready           (awready),
    .wvalid            (wvalid),
    .wdata             (wdata),
    .wstrb             (wstrb),
    .wready            (wready),
    .bvalid            (bvalid),
    .bresp             (bresp),
    .bready            (bready),
    .arvalid           (arvalid),
    .araddr            (araddr),
    .arready           (arready),
    .rvalid            (rvalid),
    .rdata             (rdata),
    .rresp             (rresp),
    .rready            (rready),
    .reg_wr_en         (reg_wr_en),
    .reg_wr_addr       (reg_wr_addr),
    .reg_wr_data       (reg_wr_data),
    .hello_swapped     (hello_swapped),
    .vled_value        (vled_value),
    // Held miner settings read straight back
    .nonce_size_value  (nonce_size),
    .hash_select_value (hash_select),
    .miner_status      (miner_status),
    .nonce             (nonce),
    .heavyhash         (heavyhash),
    .cnt_value         (cnt_value),
    .cnt_ge_watermark  (cnt_ge_watermark),
    .hash_re           (hash_re)
  );

  // ------------------------------
  // Datapath register groups
  // ------------------------------
  led_status u_led_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .vdip            (vdip),
    .hello_swapped   (hello_swapped),
    .vled_value      (vled_value),
    .vled            (vled)
  );

  miner_cmd_regs u_miner_cmd_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .block_header    (block_header),
    .block_header_we (block_header_we),
    .matrix_in       (matrix_in),
    .matrix_we       (matrix_we),
    .target          (target),
    .target_we       (target_we),
    .nonce_size      (nonce_size),
    .start           (start),
    .stop            (stop),
    .hash_select     (hash_select)
  );

  tick_counter u_tick_counter (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .reg_wr_en        (reg_wr_en),
    .reg_wr_addr      (reg_wr_addr),
    .reg_wr_data      (reg_wr_data),
    .cnt_value        (cnt_value),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

endmodule

`default_nettype wire

// File: design/cl_regs_pkg.sv
/*
 * Miner register block definitions
 * Shared widths, register map, FSM state and command opcode types
 * for the AXI4-Lite control path and the datapath register modules
 */

`default_nettype none

package cl_regs_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int led_w      = 16;
  localparam int blk_cnt    = 16;
  // Slot index into the miner hash buffer
  localparam int hash_sel_w = $clog2(blk_cnt);
  localparam int tick_w     = 8;
  // Event count, also the load and watermark width
  localparam int cnt_w      = 16;

  // ------------------------------
  // Register map, byte addresses
  // ------------------------------
  localparam logic [addr_w-1:0] hello_addr         = 32'h0000_0500;
  localparam logic [addr_w-1:0] vled_addr          = 32'h0000_0504;
  // Miner command words
  localparam logic [addr_w-1:0] block_header_addr  = 32'h0000_0510;
  localparam logic [addr_w-1:0] matrix_addr        = 32'h0000_0514;
  localparam logic [addr_w-1:0] target_addr        = 32'h0000_0518;
  localparam logic [addr_w-1:0] nonce_size_addr    = 32'h0000_051C;
  localparam logic [addr_w-1:0] start_addr         = 32'h0000_0520;
  localparam logic [addr_w-1:0] stop_addr          = 32'h0000_0524;
  localparam logic [addr_w-1:0] hash_sel_addr      = 32'h0000_0528;
  // Miner results, read only
  localparam logic [addr_w-1:0] status_addr        = 32'h0000_0530;
  localparam logic [addr_w-1:0] nonce_addr         = 32'h0000_0534;
  localparam logic [addr_w-1:0] heavyhash_addr     = 32'h0000_0538;
  // Tick counter, ctrl bit 0 enable, bit 1 one-shot
  localparam logic [addr_w-1:0] cnt_ctrl_addr      = 32'h0000_0540;
  localparam logic [addr_w-1:0] tick_value_addr    = 32'h0000_0544;
  localparam logic [addr_w-1:0] cnt_load_addr      = 32'h0000_0548;
  localparam logic [addr_w-1:0] cnt_watermark_addr = 32'h0000_054C;
  localparam logic [addr_w-1:0] cnt_cmd_addr       = 32'h0000_0550;
  // Count in 15..0, watermark flag in 16
  localparam logic [addr_w-1:0] cnt_addr           = 32'h0000_0554;

  // ------------------------------
  // Other constants
  // ------------------------------
  localparam logic [data_w-1:0] unmapped_value = 32'hDEAD_BEEF;
  localparam logic [1:0]        resp_okay      = 2'b00;

  // ------------------------------
  // Types
  // ------------------------------
  typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_t;

  typedef enum logic [1:0] {rd_idle, rd_fetch, rd_resp} rd_state_t;

  // Opcode written to cnt_cmd_addr
  typedef enum logic [1:0] {
    cnt_nop   = 2'd0,
    cnt_clear = 2'd1,
    cnt_load  = 2'd2
  } cnt_op_t;

endpackage

`default_nettype wire

// File: design/led_status.sv
/*
 * Hello scratch register and virtual LEDs
 * Hello word reads back byte-swapped; its low half drives the LEDs,
 * masked by the synchronized DIP switches
 */

`timescale 1ns/1ps
`default_nettype none

module led_status import cl_regs_pkg::*;
(
  input  wire logic              clk_main_a0,
  input  wire logic              rst_main_n_sync,
  input  wire logic              reg_wr_en,
  input  wire logic [addr_w-1:0] reg_wr_addr,
  input  wire logic [data_w-1:0] reg_wr_data,
  input  wire logic [led_w-1:0]  vdip,
  output logic [data_w-1:0]      hello_swapped,
  output logic [led_w-1:0]       vled_value,
  output logic [led_w-1:0]       vled
);

  logic [data_w-1:0] hello_q;
  logic [led_w-1:0]  vdip_q1;
  logic [led_w-1:0]  vdip_q2;

  // ------------------------------
  // Hello register
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      hello_q <= '0;
    else if (reg_wr_en && (reg_wr_addr == hello_addr))
      hello_q <= reg_wr_data;
  end

  // Byte order reversed on readback
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ------------------------------
  // LEDs
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vled_value <= '0;
      vdip_q1    <= '0;
      vdip_q2    <= '0;
      vled       <= '0;
    end
    else
    begin
      // LED shadow of the hello low half
      vled_value <= hello_q[led_w-1:0];
      // Two-flop sync of the DIP inputs
      vdip_q1    <= vdip;
      vdip_q2    <= vdip_q1;
      vled       <= vled_value & vdip_q2;
    end
  end

endmodule

`default_nettype wire

// File: design/miner_cmd_regs.sv
/*
 * Miner command registers
 * Latches header, matrix, target and nonce range words for the miner
 * core and issues one-cycle write, start and stop strobes
 */

`timescale 1ns/1ps
`default_nettype none

module miner_cmd_regs import cl_regs_pkg::*;
(
  input  wire logic              clk_main_a0,
  input  wire logic              rst_main_n_sync,
  input  wire logic              reg_wr_en,
  input  wire logic [addr_w-1:0] reg_wr_addr,
  input  wire logic [data_w-1:0] reg_wr_data,
  output logic [data_w-1:0]      block_header,
  output logic                   block_header_we,
  output logic [data_w-1:0]      matrix_in,
  output logic                   matrix_we,
  output logic [data_w-1:0]      target,
  output logic                   target_we,
  output logic [data_w-1:0]      nonce_size,
  output logic                   start,
  output logic                   stop,
  output logic [hash_sel_w-1:0]  hash_select
);

  logic hit_header;
  logic hit_matrix;
  logic hit_target;
  logic hit_nonce_size;
  logic hit_start;
  logic hit_stop;
  logic hit_hash_sel;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign hit_header     = reg_wr_en && (reg_wr_addr == block_header_addr);
  assign hit_matrix     = reg_wr_en && (reg_wr_addr == matrix_addr);
  assign hit_target     = reg_wr_en && (reg_wr_addr == target_addr);
  assign hit_nonce_size = reg_wr_en && (reg_wr_addr == nonce_size_addr);
  assign hit_start      = reg_wr_en && (reg_wr_addr == start_addr);
  assign hit_stop       = reg_wr_en && (reg_wr_addr == stop_addr);
  assign hit_hash_sel   = reg_wr_en && (reg_wr_addr == hash_sel_addr);

  // ------------------------------
  // Data words
  // ------------------------------
  // Held after the strobe so the miner can sample late
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      block_header <= '0;
      matrix_in    <= '0;
      target       <= '0;
      nonce_size   <= '0;
      hash_select  <= '0;
    end
    else
    begin
      if (hit_header)
        block_header <= reg_wr_data;
      if (hit_matrix)
        matrix_in <= reg_wr_data;
      if (hit_target)
        target <= reg_wr_data;
      if (hit_nonce_size)
        nonce_size <= reg_wr_data;
      // Upper bits dropped
      if (hit_hash_sel)
        hash_select <= reg_wr_data[hash_sel_w-1:0];
    end
  end

  // ------------------------------
  // Strobes
  // ------------------------------
  // High for one cycle after the matching beat
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      block_header_we <= 1'b0;
      matrix_we       <= 1'b0;
      target_we       <= 1'b0;
      start           <= 1'b0;
      stop            <= 1'b0;
    end
    else
    begin
      block_header_we <= hit_header;
      matrix_we       <= hit_matrix;
      target_we       <= hit_target;
      // Start and stop carry no data
      start           <= hit_start;
      stop            <= hit_stop;
    end
  end

endmodule

`default_nettype wire

// File: design/tick_counter.sv
/*
 * Prescaled tick counter
 * Prescaler wraps at the tick value, each wrap bumps a 16-bit count;
 * clear and load commands, one-shot saturation and a watermark flag
 */

`timescale 1ns/1ps
`default_nettype none

module tick_counter import cl_regs_pkg::*;
(
  input  wire logic              clk_main_a0,
  input  wire logic              rst_main_n_sync,
  input  wire logic              reg_wr_en,
  input  wire logic [addr_w-1:0] reg_wr_addr,
  input  wire logic [data_w-1:0] reg_wr_data,
  output logic [cnt_w-1:0]       cnt_value,
  output logic                   cnt_ge_watermark
);

  logic              cnt_enable;
  logic              cnt_oneshot;
  logic [tick_w-1:0] tick_value;
  logic [cnt_w-1:0]  load_value;
  logic [cnt_w-1:0]  watermark;
  logic [tick_w-1:0] prescale;
  logic              tick;
  logic              cmd_hit;
  cnt_op_t           cmd_op;

  assign cmd_hit = reg_wr_en && (reg_wr_addr == cnt_cmd_addr);
  assign cmd_op  = cnt_op_t'(reg_wr_data[1:0]);
  // Prescaler wrap point
  assign tick    = (prescale >= tick_value);

  // ------------------------------
  // Control registers
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end
    else if (reg_wr_en)
    begin
      case (reg_wr_addr)
        cnt_ctrl_addr:
        begin
          cnt_enable  <= reg_wr_data[0];
          cnt_oneshot <= reg_wr_data[1];
        end
        tick_value_addr:    tick_value <= reg_wr_data[tick_w-1:0];
        cnt_load_addr:      load_value <= reg_wr_data[cnt_w-1:0];
        cnt_watermark_addr: watermark  <= reg_wr_data[cnt_w-1:0];
        default:            ;
      endcase
    end
  end

  // ------------------------------
  // Prescaler and count
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      prescale  <= '0;
      cnt_value <= '0;
    end
    else if (cmd_hit && (cmd_op == cnt_clear))
    begin
      prescale  <= '0;
      cnt_value <= '0;
    end
    else if (cmd_hit && (cmd_op == cnt_load))
      cnt_value <= load_value;
    else if (cnt_enable)
    begin
      prescale <= tick ? '0 : prescale + 1'b1;
      // One-shot holds at full scale
      if (tick && !(cnt_oneshot && (cnt_value == {cnt_w{1'b1}})))
        cnt_value <= cnt_value + 1'b1;
    end
  end

  assign cnt_ge_watermark = (cnt_value >= watermark);

endmodule

`default_nettype wire

// File: tb/tb_tasks.svh
/*
 * Testbench tasks for the miner register block
 * AXI4-Lite single-beat write and read, value check, handshake wait
 * and the directed tests
 */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ------------------------------
// Helpers
// ------------------------------
// Inputs change 1 ns after the rising edge
task automatic next_cycle();
  @(posedge clk_main_a0);
  #1;
endtask

task automatic timeout_fail(input string what);
  $display("Timeout: no %s within %0d cycles in %s", what, hs_timeout, test_name);
  $display("sim failed");
  $fatal(1);
endtask

task automatic check(input string what, input logic [31:0] expected,
                     input logic [31:0] actual);
  if (actual !== expected)
  begin
    $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    $display("sim failed");
    $fatal(1);
  end
endtask

// Ready/valid sampled at the falling edge, transfer on the next rise
task automatic wait_handshake(input int chan, input string what);
  int   cycles;
  logic seen;
  cycles = 0;
  seen   = 1'b0;
  while (!seen)
  begin
    @(negedge clk_main_a0);
    case (chan)
      ch_aw:   seen = awready;
      ch_w:    seen = wready;
      ch_b:    seen = bvalid;
      ch_ar:   seen = arready;
      default: seen = rvalid;
    endcase
    if (seen && (chan == ch_b))
      last_resp = bresp;
    if (seen && (chan == ch_r))
    begin
      last_resp  = rresp;
      last_rdata = rdata;
    end
    next_cycle();
    cycles++;
    if (!seen && (cycles >= hs_timeout))
      timeout_fail(what);
  end
endtask

function automatic logic [31:0] byte_reverse(input logic [31:0] word);
  logic [31:0] result;
  int          b;
  for (b = 0; b < 4; b++)
    result[8*(3-b) +: 8] = word[8*b +: 8];
  return result;
endfunction

// ------------------------------
// AXI4-Lite transfers
// ------------------------------
task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
  awvalid = 1'b1;
  awaddr  = addr;
  wait_handshake(ch_aw, "write address handshake");
  awvalid = 1'b0;
  wvalid  = 1'b1;
  wdata   = data;
  wstrb   = '1;
  wait_handshake(ch_w, "write data handshake");
  wvalid  = 1'b0;
  wstrb   = '0;
  bready  = 1'b1;
  wait_handshake(ch_b, "write response");
  bready  = 1'b0;
  check("bresp", 32'(resp_okay), 32'(last_resp));
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
  arvalid = 1'b1;
  araddr  = addr;
  wait_handshake(ch_ar, "read address handshake");
  arvalid = 1'b0;
  rready  = 1'b1;
  wait_handshake(ch_r, "read data");
  rready  = 1'b0;
  check("rresp", 32'(resp_okay), 32'(last_resp));
  data = last_rdata;
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic test_reset_state();
  test_name = "test_reset_state";
  check("awready", 32'd1, 32'(awready));
  check("arready", 32'd1, 32'(arready));
  check("bvalid", 32'd0, 32'(bvalid));
  check("rvalid", 32'd0, 32'(rvalid));
  check("vled", 32'd0, 32'(vled));
endtask

task automatic test_hello_swap();
  logic [31:0] word;
  logic [31:0] rd;
  test_name = "test_hello_swap";
  word = lfsr_bits(32);
  axil_write(hello_addr, word);
  axil_read(hello_addr, rd);
  check("hello readback", byte_reverse(word), rd);
  // Hole in the map
  axil_read(32'h0000_05FC, rd);
  check("unmapped read", unmapped_value, rd);
endtask

task automatic test_vled();
  logic [31:0] word;
  logic [31:0] tmp;
  logic [15:0] exp_led;
  logic [31:0] rd;
  int          cycles;
  test_name = "test_vled";
  tmp     = lfsr_bits(16);
  vdip    = tmp[15:0];
  word    = lfsr_bits(32);
  exp_led = word[15:0] & tmp[15:0];
  axil_write(hello_addr, word);
  cycles = 0;
  while (vled !== exp_led)
  begin
    next_cycle();
    cycles++;
    if (cycles >= hs_timeout)
      timeout_fail("vled update");
  end
  // Readback is the unmasked hello low half
  axil_read(vled_addr, rd);
  check("vled register", {16'b0, word[15:0]}, rd);
endtask

function automatic logic [31:0] strobe_addr(input int idx);
  case (idx)
    0:       return block_header_addr;
    1:       return matrix_addr;
    2:       return target_addr;
    3:       return start_addr;
    default: return stop_addr;
  endcase
endfunction

function automatic logic [31:0] strobe_port(input int idx);
  case (idx)
    0:       return block_header;
    1:       return matrix_in;
    default: return target;
  endcase
endfunction

task automatic test_miner_cmds();
  int          snap [5];
  int          cycles;
  int          i;
  int          j;
  logic [31:0] word;
  logic [31:0] rd;
  test_name = "test_miner_cmds";
  for (i = 0; i < 5; i++)
  begin
    snap = strobe_cnt;
    word = lfsr_bits(32);
    axil_write(strobe_addr(i), word);
    cycles = 0;
    while (strobe_cnt[i] == snap[i])
    begin
      next_cycle();
      cycles++;
      if (cycles >= hs_timeout)
        timeout_fail("command strobe");
    end
    // Any second pulse would land here
    repeat (3) next_cycle();
    for (j = 0; j < 5; j++)
      check($sformatf("pulses on strobe %0d", j), (i == j) ? 1 : 0, strobe_cnt[j] - snap[j]);
    if (i < 3)
    begin
      check("data at strobe", word, strobe_data[i]);
      check("data held", word, strobe_port(i));
    end
  end
  word = lfsr_bits(32);
  axil_write(nonce_size_addr, word);
  axil_read(nonce_size_addr, rd);
  check("nonce size", word, rd);
  check("nonce size port", word, nonce_size);
  word = lfsr_bits(32);
  axil_write(hash_sel_addr, word);
  axil_read(hash_sel_addr, rd);
  // Only four select bits survive
  check("hash select", word & 32'h0000_000F, rd);
  check("hash select port", word & 32'h0000_000F, 32'(hash_select));
endtask

task automatic test_miner_readback();
  logic [31:0] tmp;
  logic [31:0] rd;
  int          snap;
  test_name = "test_miner_readback";
  tmp          = lfsr_bits(2);
  miner_status = tmp[1:0];
  nonce        = lfsr_bits(32);
  heavyhash    = lfsr_bits(32);
  axil_read(status_addr, rd);
  check("status", {30'b0, tmp[1:0]}, rd);
  snap = hash_re_cnt;
  axil_read(nonce_addr, rd);
  check("nonce", nonce, rd);
  check("hash_re on nonce read", 32'd0, hash_re_cnt - snap);
  snap = hash_re_cnt;
  axil_read(heavyhash_addr, rd);
  check("heavyhash", heavyhash, rd);
  check("hash_re on heavyhash read", 32'd1, hash_re_cnt - snap);
endtask

task automatic test_tick_counter();
  logic [31:0] tmp;
  logic [31:0] rd;
  logic [15:0] load;
  logic [15:0] wm;
  int          polls;
  test_name = "test_tick_counter";
  tmp  = lfsr_bits(12);
  load = tmp[15:0];
  wm   = load + 16'd3;
  axil_write(cnt_ctrl_addr, 32'd0);
  axil_write(cnt_watermark_addr, {16'b0, wm});
  axil_write(cnt_load_addr, {16'b0, load});
  axil_write(cnt_cmd_addr, 32'(cnt_load));
  axil_read(cnt_addr, rd);
  // Disabled, so the load value stays put and the flag is low
  check("loaded count", {16'b0, load}, rd);
  axil_write(tick_value_addr, 32'd0);
  axil_write(cnt_ctrl_addr, 32'd1);
  polls = 0;
  axil_read(cnt_addr, rd);
  while (!rd[16])
  begin
    polls++;
    if (polls >= 20)
      timeout_fail("watermark flag");
    axil_read(cnt_addr, rd);
  end
  check("count at watermark", 32'd1, 32'(rd[15:0] >= wm));
  axil_write(cnt_ctrl_addr, 32'd0);
  axil_write(cnt_cmd_addr, 32'(cnt_clear));
  axil_read(cnt_addr, rd);
  check("cleared count", 32'd0, rd);
endtask

`endif

// File: tb/tb_cl_miner_regs.sv
/*
 * Testbench for the miner register block
 * Clock, reset, LFSR stimulus source, strobe monitor and the
 * directed test sequence over the AXI4-Lite port
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cl_miner_regs import cl_regs_pkg::*; ();

  // Handshake wait limit in cycles
  localparam int hs_timeout = 50;
  // Channel ids for the handshake wait
  localparam int ch_aw = 0;
  localparam int ch_w  = 1;
  localparam int ch_b  = 2;
  localparam int ch_ar = 3;
  localparam int ch_r  = 4;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                  clk_main_a0;
  logic                  rst_main_n_sync;
  logic                  awvalid;
  logic [addr_w-1:0]     awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [data_w-1:0]     wdata;
  logic [data_w/8-1:0]   wstrb;
  logic                  wready;
  logic                  bvalid;
  logic [1:0]            bresp;
  logic                  bready;
  logic                  arvalid;
  logic [addr_w-1:0]     araddr;
  logic                  arready;
  logic                  rvalid;
  logic [data_w-1:0]     rdata;
  logic [1:0]            rresp;
  logic                  rready;
  logic [data_w-1:0]     block_header;
  logic                  block_header_we;
  logic [data_w-1:0]     matrix_in;
  logic                  matrix_we;
  logic [data_w-1:0]     target;
  logic                  target_we;
  logic [data_w-1:0]     nonce_size;
  logic                  start;
  logic                  stop;
  logic [hash_sel_w-1:0] hash_select;
  logic                  hash_re;
  logic [1:0]            miner_status;
  logic [data_w-1:0]     nonce;
  logic [data_w-1:0]     heavyhash;
  logic [led_w-1:0]      vdip;
  logic [led_w-1:0]      vled;

  // ------------------------------
  // Testbench state
  // ------------------------------
  string       test_name;
  logic [31:0] lfsr_state;
  // Last response seen on B or R
  logic [1:0]  last_resp;
  logic [31:0] last_rdata;
  // Pulse counts: header, matrix, target, start, stop
  int          strobe_cnt [5];
  bit   [31:0] strobe_data [3];
  int          hash_re_cnt;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] bits;
    logic        fb;
    int          k;
    bits = '0;
    for (k = 0; k < count; k++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  `include "tb_tasks.svh"

  // ------------------------------
  // DUT
  // ------------------------------
  cl_miner_regs u_cl_miner_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .block_header    (block_header),
    .block_header_we (block_header_we),
    .matrix_in       (matrix_in),
    .matrix_we       (matrix_we),
    .target          (target),
    .target_we       (target_we),
    .nonce_size      (nonce_size),
    .start           (start),
    .stop            (stop),
    .hash_select     (hash_select),
    .hash_re         (hash_re),
    .miner_status    (miner_status),
    .nonce           (nonce),
    .heavyhash       (heavyhash),
    .vdip            (vdip),
    .vled            (vled)
  );

  // 8 ns period
  always #4 clk_main_a0 = ~clk_main_a0;

  // Strobe monitor, sampled mid-cycle
  always @(negedge clk_main_a0)
  begin
    if (block_header_we)
    begin
      strobe_cnt[0]  = strobe_cnt[0] + 1;
      strobe_data[0] = block_header;
    end
    if (matrix_we)
    begin
      strobe_cnt[1]  = strobe_cnt[1] + 1;
      strobe_data[1] = matrix_in;
    end
    if (target_we)
    begin
      strobe_cnt[2]  = strobe_cnt[2] + 1;
      strobe_data[2] = target;
    end
    if (start)
      strobe_cnt[3] = strobe_cnt[3] + 1;
    if (stop)
      strobe_cnt[4] = strobe_cnt[4] + 1;
    if (hash_re)
      hash_re_cnt = hash_re_cnt + 1;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    lfsr_state      = 32'h530d_4584;
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    miner_status    = '0;
    nonce           = '0;
    heavyhash       = '0;
    vdip            = '0;
    last_resp       = '0;
    last_rdata      = '0;
    test_name       = "reset";
    // Reset low for two rising edges
    repeat (2) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    next_cycle();
    test_reset_state();
    test_hello_swap();
    test_vled();
    test_miner_cmds();
    test_miner_readback();
    test_tick_counter();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
